//--- Makefile
# Verilator build and run for the memwb testbench
TOP       ?= memwb_tb
FILELIST  ?= memwb.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Status comes from the pass message in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- design/memwb_config.svh
`ifndef MEMWB_CONFIG_SVH
`define MEMWB_CONFIG_SVH

// Data and address width
`define MEMWB_XLEN 32

// Data memory depth in words where upper address bits wrap
`define MEMWB_MEM_WORDS 256

// Architectural register count
`define MEMWB_NREGS 32

`endif

//--- design/memwb_gpr.sv
`include "memwb_config.svh"

module memwb_gpr (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            commit_valid,
    input  memwb_pkg::commit_t              commit,
    input  logic [$clog2(`MEMWB_NREGS)-1:0] dbg_addr,
    output logic [`MEMWB_XLEN-1:0]          dbg_data
);

    logic [`MEMWB_XLEN-1:0] regs [`MEMWB_NREGS];
    logic                   wr_en;

    // Writes to x0 are dropped so it holds its reset value of zero
    assign wr_en = commit_valid && commit.we && (commit.rd != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MEMWB_NREGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[commit.rd] <= commit.data;
        end
    end

    assign dbg_data = regs[dbg_addr];

endmodule

//--- design/memwb_lsu.sv
`include "memwb_config.svh"

module memwb_lsu (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    input  memwb_pkg::mem_cmd_t    cmd,
    input  logic                   wbu_ready,
    output logic                   cmd_ready,
    output logic                   lsu_valid,
    output memwb_pkg::lsu_to_wbu_t lsu_out
);

    localparam int NBYTES = `MEMWB_XLEN / 8;
    localparam int OFF_W  = $clog2(NBYTES);
    localparam int IDX_W  = $clog2(`MEMWB_MEM_WORDS);

    memwb_pkg::stage_state_e state;

    logic [`MEMWB_XLEN-1:0] mem [`MEMWB_MEM_WORDS];
    logic [IDX_W-1:0]       idx;
    logic [IDX_W-1:0]       idx_q;
    logic [OFF_W-1:0]       off;
    logic [NBYTES-1:0]      base_be;
    logic [NBYTES-1:0]      be;
    logic [`MEMWB_XLEN-1:0] wdata_sh;
    logic                   accept;
    logic                   handoff;

    memwb_pkg::lsu_to_wbu_t out_q;

    assign handoff   = lsu_valid && wbu_ready;
    assign cmd_ready = (state == memwb_pkg::ST_IDLE) || handoff;   // Refill on hand-off edge
    assign accept    = cmd_valid && cmd_ready;

    assign off = cmd.addr[OFF_W-1:0];
    assign idx = cmd.addr[OFF_W +: IDX_W];

    always_comb begin
        case (cmd.op)
            memwb_pkg::OP_SB: base_be = NBYTES'(1);
            memwb_pkg::OP_SH: base_be = NBYTES'(3);
            memwb_pkg::OP_SW: base_be = '1;
            default:          base_be = '0;   // Loads and moves leave memory alone
        endcase
    end

    // Lanes shifted past the top byte fall off
    assign be       = base_be << off;
    assign wdata_sh = cmd.wdata << {off, 3'b000};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= memwb_pkg::ST_IDLE;
            lsu_valid <= 1'b0;
        end else begin
            case (state)
                memwb_pkg::ST_IDLE: begin
                    if (accept)
                        state <= memwb_pkg::ST_BUSY;
                end
                memwb_pkg::ST_BUSY: begin
                    if (!lsu_valid) begin
                        lsu_valid <= 1'b1;   // Read data lands this edge
                    end else if (handoff) begin
                        lsu_valid <= 1'b0;
                        if (!accept)
                            state <= memwb_pkg::ST_IDLE;
                    end
                end
                default: state <= memwb_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < NBYTES; i++) begin
                if (be[i])
                    mem[idx][8*i +: 8] <= wdata_sh[8*i +: 8];
            end
            idx_q           <= idx;
            out_q.op        <= cmd.op;
            out_q.rd        <= cmd.rd;
            out_q.addr_lo   <= off;
            out_q.move_data <= cmd.wdata;
        end
        // Synchronous read one edge after acceptance
        if (state == memwb_pkg::ST_BUSY && !lsu_valid)
            out_q.rdata <= mem[idx_q];
    end

    assign lsu_out = out_q;

endmodule

//--- design/memwb_pkg.sv
`include "memwb_config.svh"

package memwb_pkg;

    typedef enum logic [3:0] {
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_MOVE     // CSR read and similar
    } mem_op_e;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } stage_state_e;

    // Command into the LSU
    typedef struct packed {
        mem_op_e                         op;
        logic [$clog2(`MEMWB_NREGS)-1:0] rd;
        logic [`MEMWB_XLEN-1:0]          addr;
        logic [`MEMWB_XLEN-1:0]          wdata;    // Move value for OP_MOVE
    } mem_cmd_t;

    typedef struct packed {
        mem_op_e                         op;
        logic [$clog2(`MEMWB_NREGS)-1:0] rd;
        logic [1:0]                      addr_lo;
        logic [`MEMWB_XLEN-1:0]          rdata;    // Raw memory word
        logic [`MEMWB_XLEN-1:0]          move_data;
    } lsu_to_wbu_t;

    typedef struct packed {
        logic                            we;
        logic [$clog2(`MEMWB_NREGS)-1:0] rd;
        logic [`MEMWB_XLEN-1:0]          data;
    } commit_t;

endpackage

//--- design/memwb_top.sv
`include "memwb_config.svh"

module memwb_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmd_valid,
    input  memwb_pkg::mem_cmd_t             cmd,
    input  logic [$clog2(`MEMWB_NREGS)-1:0] dbg_addr,
    output logic                            cmd_ready,
    output logic                            commit_valid,
    output memwb_pkg::commit_t              commit,
    output logic [`MEMWB_XLEN-1:0]          dbg_data
);

    logic                   lsu_valid;
    logic                   wbu_ready;
    memwb_pkg::lsu_to_wbu_t lsu_out;

    memwb_lsu i_lsu (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .wbu_ready (wbu_ready),
        .cmd_ready (cmd_ready),
        .lsu_valid (lsu_valid),
        .lsu_out   (lsu_out)
    );

    memwb_wbu i_wbu (
        .clk          (clk),
        .rst          (rst),
        .lsu_valid    (lsu_valid),
        .lsu_out      (lsu_out),
        .wbu_ready    (wbu_ready),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    // Commit goes to the register file and out of the top
    memwb_gpr i_gpr (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit       (commit),
        .dbg_addr     (dbg_addr),
        .dbg_data     (dbg_data)
    );

endmodule

//--- design/memwb_wbu.sv
`include "memwb_config.svh"

module memwb_wbu (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   lsu_valid,
    input  memwb_pkg::lsu_to_wbu_t lsu_out,
    output logic                   wbu_ready,
    output logic                   commit_valid,
    output memwb_pkg::commit_t     commit
);

    localparam int XLEN = `MEMWB_XLEN;

    memwb_pkg::stage_state_e state;
    memwb_pkg::lsu_to_wbu_t  in_q;

    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] result;
    logic            result_we;

    assign wbu_ready = (state == memwb_pkg::ST_IDLE);

    always_ff @(posedge clk) begin
        if (lsu_valid && wbu_ready)
            in_q <= lsu_out;
    end

    // Align the addressed byte or half to bit 0 with zero fill from the top
    assign shifted = in_q.rdata >> {in_q.addr_lo, 3'b000};

    always_comb begin
        case (in_q.op)
            memwb_pkg::OP_LB:   result = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            memwb_pkg::OP_LBU:  result = {{(XLEN-8){1'b0}}, shifted[7:0]};
            memwb_pkg::OP_LH:   result = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            memwb_pkg::OP_LHU:  result = {{(XLEN-16){1'b0}}, shifted[15:0]};
            memwb_pkg::OP_LW:   result = shifted;
            memwb_pkg::OP_MOVE: result = in_q.move_data;
            default:            result = '0;   // Stores
        endcase
    end

    always_comb begin
        case (in_q.op)
            memwb_pkg::OP_SB,
            memwb_pkg::OP_SH,
            memwb_pkg::OP_SW: result_we = 1'b0;
            default:          result_we = 1'b1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= memwb_pkg::ST_IDLE;
            commit_valid <= 1'b0;
            commit       <= '0;
        end else begin
            commit_valid <= 1'b0;   // One-cycle strobe
            case (state)
                memwb_pkg::ST_IDLE: begin
                    if (lsu_valid)
                        state <= memwb_pkg::ST_BUSY;
                end
                memwb_pkg::ST_BUSY: begin
                    commit.we    <= result_we;
                    commit.rd    <= in_q.rd;
                    commit.data  <= result;
                    commit_valid <= 1'b1;
                    state        <= memwb_pkg::ST_IDLE;
                end
                default: state <= memwb_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

//--- memwb.f
+incdir+design
+incdir+tb
design/memwb_pkg.sv
design/memwb_lsu.sv
design/memwb_wbu.sv
design/memwb_gpr.sv
design/memwb_top.sv
tb/memwb_tb.sv

//--- tb/memwb_tb_model.svh
`ifndef MEMWB_TB_MODEL_SVH
`define MEMWB_TB_MODEL_SVH

logic [`MEMWB_XLEN-1:0] model_mem [`MEMWB_MEM_WORDS];
logic [`MEMWB_XLEN-1:0] model_regs [`MEMWB_NREGS] = '{default: '0};
logic [31:0]            rng_state = 32'd75795;

function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Applies one command to the model and returns the commit it should produce
function automatic memwb_pkg::commit_t model_apply(memwb_pkg::mem_cmd_t c);
    memwb_pkg::commit_t     exp;
    logic [`MEMWB_XLEN-1:0] word;
    int                     idx;
    int                     off;
    int                     len;
    idx  = int'((c.addr >> 2) % `MEMWB_MEM_WORDS);   // Upper address bits wrap
    off  = int'(c.addr % 4);
    len  = (c.op == memwb_pkg::OP_SB) ? 1 : (c.op == memwb_pkg::OP_SH) ? 2 :
           (c.op == memwb_pkg::OP_SW) ? 4 : 0;
    word = model_mem[idx] >> (8 * off);
    for (int b = 0; b < `MEMWB_XLEN / 8; b++) begin
        if (b >= off && b < off + len)
            model_mem[idx][8*b +: 8] = c.wdata[8*(b-off) +: 8];
    end
    exp.we = (len == 0);
    exp.rd = c.rd;
    case (c.op)
        memwb_pkg::OP_LB:   exp.data = 32'($signed(word[7:0]));
        memwb_pkg::OP_LBU:  exp.data = 32'(word[7:0]);
        memwb_pkg::OP_LH:   exp.data = 32'($signed(word[15:0]));
        memwb_pkg::OP_LHU:  exp.data = 32'(word[15:0]);
        memwb_pkg::OP_LW:   exp.data = word;
        memwb_pkg::OP_MOVE: exp.data = c.wdata;
        default:            exp.data = '0;
    endcase
    if (exp.we && c.rd != '0)
        model_regs[c.rd] = exp.data;
    return exp;
endfunction

// Stores only have a defined write enable
task automatic check_commit(memwb_pkg::commit_t exp, memwb_pkg::commit_t act);
    if (act.we !== exp.we || (exp.we && (act.rd !== exp.rd || act.data !== exp.data))) begin
        $display("ERR %0t commit: expected we=%0b rd=%0d data=%h, got we=%0b rd=%0d data=%h",
                 $time, exp.we, exp.rd, exp.data, act.we, act.rd, act.data);
        err_cnt++;
    end
endtask

task automatic check_reg(int idx, logic [`MEMWB_XLEN-1:0] exp, logic [`MEMWB_XLEN-1:0] act);
    if (act !== exp) begin
        $display("ERR %0t dbg_data x%0d: expected %h, got %h", $time, idx, exp, act);
        err_cnt++;
    end
endtask

task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
        $display("ERR %0t %s: expected %b, got %b", $time, name, exp, act);
        err_cnt++;
    end
endtask

task automatic check_cycles(int exp, int act);
    if (act != exp) begin
        $display("ERR %0t commit_valid latency: expected %0d, got %0d", $time, exp, act);
        err_cnt++;
    end
endtask

`endif

//--- tb/memwb_tb.sv
`include "memwb_config.svh"

module memwb_tb;

    localparam int PERIOD     = 40;
    localparam int RST_CYCLES = 5;
    localparam int N_RAND     = 40;
    localparam int N_STEPS    = 56 + N_RAND + 88;   // Commands plus debug reads
    localparam int WD_CYCLES  = RST_CYCLES + 10 * N_STEPS;

    logic                            clk;
    logic                            rst;
    logic                            cmd_valid;
    memwb_pkg::mem_cmd_t             cmd;
    logic [$clog2(`MEMWB_NREGS)-1:0] dbg_addr;
    logic                            cmd_ready;
    logic                            commit_valid;
    memwb_pkg::commit_t              commit;
    logic [`MEMWB_XLEN-1:0]          dbg_data;

    int err_cnt  = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int edge_cnt = 0;
    memwb_pkg::commit_t exp_q[$];
    int                 acc_q[$];   // Accepting edge of each outstanding command

    `include "memwb_tb_model.svh"

    memwb_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .dbg_addr     (dbg_addr),
        .cmd_ready    (cmd_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .dbg_data     (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("Commit at %0t arrived with no command outstanding", $time);
                err_cnt++;
            end else begin
                check_commit(exp_q.pop_front(), commit);
                check_cycles(3, edge_cnt - acc_q.pop_front());
            end
        end
    end

    initial begin
        #(WD_CYCLES * PERIOD);
        $display("Watchdog timeout after %0d cycles, the run did not complete", WD_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // Called just after a rising edge and returns on the accepting edge
    task automatic issue(memwb_pkg::mem_op_e op, logic [$clog2(`MEMWB_NREGS)-1:0] rd,
                         logic [`MEMWB_XLEN-1:0] addr, logic [`MEMWB_XLEN-1:0] data);
        memwb_pkg::mem_cmd_t c;
        logic                seen;
        int                  acc;
        c.op      = op;
        c.rd      = rd;
        c.addr    = addr;
        c.wdata   = data;
        cmd_valid <= 1'b1;
        cmd       <= c;
        seen      = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = cmd_ready;
            acc  = edge_cnt + 1;
            @(posedge clk);
        end
        exp_q.push_back(model_apply(c));
        acc_q.push_back(acc);
    endtask

    task automatic drain();
        int wait_cnt;
        cmd_valid <= 1'b0;
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("No commit seen for %0d outstanding commands at %0t", exp_q.size(), $time);
            err_cnt++;
            exp_q.delete();
            acc_q.delete();
        end
    endtask

    task automatic read_reg(int idx);
        dbg_addr <= idx[4:0];
        @(negedge clk);
        check_reg(idx, model_regs[idx], dbg_data);
        @(posedge clk);
    endtask

    task automatic end_test(string name, int err_before);
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("test %-16s ok", name);
        end else begin
            fail_cnt++;
            $display("test %-16s %0d errors", name, err_cnt - err_before);
        end
    endtask

    initial begin
        int          e;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        dbg_addr  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        e = err_cnt;
        @(negedge clk);
        check_flag("cmd_ready", 1'b1, cmd_ready);
        check_flag("commit_valid", 1'b0, commit_valid);
        @(posedge clk);
        for (int i = 0; i < `MEMWB_NREGS; i++)
            read_reg(i);
        end_test("reset", e);

        e = err_cnt;
        issue(memwb_pkg::OP_SW, 5'd1, 32'h0000_0040, 32'hCAFE_F00D);
        issue(memwb_pkg::OP_LW, 5'd3, 32'h0000_0040, '0);
        issue(memwb_pkg::OP_SW, 5'd2, 32'h0000_0444, 32'h1234_5678);   // Aliases word 0x11
        issue(memwb_pkg::OP_LW, 5'd4, 32'h0000_0044, '0);
        drain();
        for (int i = 1; i < 5; i++)
            read_reg(i);
        end_test("word store/load", e);

        e = err_cnt;
        issue(memwb_pkg::OP_SW, 5'd0, 32'h100, 32'hF1E2_D3C4);
        for (int k = 0; k < 4; k++) begin
            issue(memwb_pkg::OP_LB,  5'(8 + 4*k), 32'h100 + k, '0);
            issue(memwb_pkg::OP_LBU, 5'(9 + 4*k), 32'h100 + k, '0);
            issue(memwb_pkg::OP_LH,  5'(10 + 4*k), 32'h100 + k, '0);
            issue(memwb_pkg::OP_LHU, 5'(11 + 4*k), 32'h100 + k, '0);
        end
        drain();
        for (int i = 8; i < 24; i++)
            read_reg(i);
        end_test("sub-word loads", e);

        e = err_cnt;
        for (int k = 0; k < 4; k++) begin
            issue(memwb_pkg::OP_SW, 5'd0, 32'h200, 32'h8899_AABB);
            issue(memwb_pkg::OP_SB, 5'd0, 32'h200 + k, 32'h1234_5611);
            issue(memwb_pkg::OP_LW, 5'd24, 32'h200, '0);
            issue(memwb_pkg::OP_SW, 5'd0, 32'h204, 32'h8899_AABB);
            issue(memwb_pkg::OP_SH, 5'd0, 32'h204 + k, 32'h1234_6622);
            issue(memwb_pkg::OP_LW, 5'd25, 32'h204, '0);
        end
        drain();
        read_reg(24);
        read_reg(25);
        end_test("sub-word stores", e);

        e = err_cnt;
        issue(memwb_pkg::OP_MOVE, 5'd5, '0, 32'hDEAD_BEEF);
        issue(memwb_pkg::OP_MOVE, 5'd0, '0, 32'h5555_AAAA);
        issue(memwb_pkg::OP_LW, 5'd0, 32'h40, '0);
        drain();
        read_reg(5);
        read_reg(0);
        end_test("moves and x0", e);

        e = err_cnt;
        for (int w = 0; w < 8; w++) begin
            d = xorshift32();
            issue(memwb_pkg::OP_SW, 5'd0, 32'(4*w), d);
        end
        repeat (N_RAND) begin
            r = xorshift32();
            a = xorshift32() & 32'hFFFF_FC1F;   // Words 0 to 7 with random upper bits
            d = xorshift32();
            issue(memwb_pkg::mem_op_e'(4'(r % 9)), r[31:27], a, d);
        end
        drain();
        for (int i = 0; i < `MEMWB_NREGS; i++)
            read_reg(i);
        end_test("random stream", e);

        $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
